// ==== hdl/csr_rs_cfg.svh ====
`ifndef CSR_RS_CFG_SVH
`define CSR_RS_CFG_SVH

// sizing of the CSR issue path

// entries in the CSR reservation station
`define CSR_RS_DEPTH 16

// physical register tag width
`define CSR_TAG_W 8

// operand and CSR word width
`define CSR_DATA_W 32

// selects one of 8 CSRs by the low bits of the 12-bit address
`define CSR_IDX_W 3

// result buses from the other execution units
`define CSR_WAKE_PORTS 4

`endif

// ==== hdl/csr_rs_pkg.sv ====
`include "csr_rs_cfg.svh"

package csr_rs_pkg;

  // low two bits of funct3 for csrrw, csrrs and csrrc
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic [31:0]             inst_num;
    logic [`CSR_TAG_W-1:0]   rd;
    logic [`CSR_TAG_W-1:0]   src;
    logic                    src_ready;  // operand already in src_data
    logic [`CSR_DATA_W-1:0]  src_data;
    logic                    use_imm;    // csrrwi, csrrsi, csrrci forms
    logic [4:0]              imm;        // zimm, zero-extended on issue
    logic [11:0]             csr_addr;
    csr_op_e                 op;
  } csr_dispatch_t;

  typedef struct packed {
    logic                    valid;
    logic [`CSR_TAG_W-1:0]   tag;
    logic [`CSR_DATA_W-1:0]  data;
  } wakeup_t;

  typedef struct packed {
    logic                    valid;
    logic [31:0]             inst_num;
    logic [`CSR_TAG_W-1:0]   rd;
    logic [`CSR_DATA_W-1:0]  operand;
    logic [11:0]             csr_addr;
    csr_op_e                 op;
  } csr_issue_t;

  typedef struct packed {
    logic                    valid;
    logic [31:0]             inst_num;
    logic [`CSR_TAG_W-1:0]   rd;
    logic [`CSR_DATA_W-1:0]  old_val;    // CSR contents before the write
  } csr_done_t;

endpackage

// ==== hdl/wakeup_merge.sv ====
`timescale 1ns/10ps
`include "csr_rs_cfg.svh"

module wakeup_merge import csr_rs_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  wakeup_t   ext_wake [`CSR_WAKE_PORTS],
  input  csr_done_t csr_done,
  output wakeup_t   wake [`CSR_WAKE_PORTS+1]
);

  localparam int NEXT = `CSR_WAKE_PORTS;

  wakeup_t done_wake;

  always_comb begin
    done_wake.valid = csr_done.valid;
    done_wake.tag   = csr_done.rd;
    done_wake.data  = csr_done.old_val[`CSR_DATA_W-1:0];
  end

  always_comb begin
    for (int p = 0; p < NEXT; p++) begin
      wake[p] = ext_wake[p];
      if (ext_wake[p].tag == '0) begin
        wake[p].valid = 1'b0;  // tag 0 is the hardwired register
      end
    end
    wake[NEXT] = done_wake;
  end

endmodule

// ==== hdl/csr_station.sv ====
`timescale 1ns/10ps
`include "csr_rs_cfg.svh"

module csr_station import csr_rs_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          flush,
  input  csr_dispatch_t dispatch,
  input  logic          dispatch_valid,
  input  wakeup_t       wake [`CSR_WAKE_PORTS+1],
  output logic          full,
  output csr_issue_t    issue
);

  localparam int DEPTH = `CSR_RS_DEPTH;
  localparam int IDXW  = $clog2(DEPTH);
  localparam int NWAKE = `CSR_WAKE_PORTS + 1;

  logic [DEPTH-1:0]       busy_q;
  logic [DEPTH-1:0]       rdy_q;
  csr_dispatch_t          ent_q [DEPTH];
  wakeup_t                ent_wake [DEPTH];
  wakeup_t                disp_wake;
  csr_dispatch_t          disp_entry;
  logic [IDXW-1:0]        free_idx;
  logic [IDXW-1:0]        iss_idx;
  logic                   iss_any;
  logic                   disp_ok;
  logic                   iss_valid_q;
  logic [31:0]            iss_inst_q;
  logic [`CSR_TAG_W-1:0]  iss_rd_q;
  logic [`CSR_DATA_W-1:0] iss_operand_q;
  logic [11:0]            iss_addr_q;
  csr_op_e                iss_op_q;

  // returns the broadcast for tag, valid low when no port carries it
  function automatic wakeup_t find_wake(input logic [`CSR_TAG_W-1:0] tag,
                                        input wakeup_t w [NWAKE]);
    wakeup_t res;
    res = '0;
    for (int p = NWAKE - 1; p >= 0; p--) begin
      if (w[p].valid && w[p].tag == tag) res = w[p];
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ent_wake[i] = find_wake(ent_q[i].src, wake);
    end
    disp_wake  = find_wake(dispatch.src, wake);
    disp_entry = dispatch;
    if (!dispatch.src_ready && disp_wake.valid) begin
      disp_entry.src_ready = 1'b1;  // producer broadcasts in the dispatch cycle
      disp_entry.src_data  = disp_wake.data;
    end
  end

  // the downward scan leaves the lowest index in both selects
  always_comb begin
    free_idx = '0;
    iss_idx  = '0;
    iss_any  = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!busy_q[i]) free_idx = IDXW'(i);
      if (busy_q[i] && rdy_q[i]) begin
        iss_idx = IDXW'(i);
        iss_any = 1'b1;
      end
    end
  end

  assign full    = &busy_q;
  assign disp_ok = dispatch_valid && !full;  // a dispatch while full is dropped

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy_q      <= '0;
      rdy_q       <= '0;
      iss_valid_q <= 1'b0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (busy_q[i] && !rdy_q[i] && ent_wake[i].valid) rdy_q[i] <= 1'b1;
      end
      if (iss_any) begin
        busy_q[iss_idx] <= 1'b0;
        rdy_q[iss_idx]  <= 1'b0;
      end
      if (disp_ok) begin
        busy_q[free_idx] <= 1'b1;
        rdy_q[free_idx]  <= disp_entry.src_ready;
      end
      iss_valid_q <= iss_any;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (busy_q[i] && !rdy_q[i] && ent_wake[i].valid) ent_q[i].src_data <= ent_wake[i].data;
    end
    if (disp_ok) ent_q[free_idx] <= disp_entry;
    if (iss_any) begin
      iss_inst_q    <= ent_q[iss_idx].inst_num;
      iss_rd_q      <= ent_q[iss_idx].rd;
      iss_operand_q <= ent_q[iss_idx].use_imm ? `CSR_DATA_W'(ent_q[iss_idx].imm)
                                              : ent_q[iss_idx].src_data;
      iss_addr_q    <= ent_q[iss_idx].csr_addr;
      iss_op_q      <= ent_q[iss_idx].op;
    end
  end

  assign issue = '{valid: iss_valid_q, inst_num: iss_inst_q, rd: iss_rd_q,
                   operand: iss_operand_q, csr_addr: iss_addr_q, op: iss_op_q};

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/10ps
`include "csr_rs_cfg.svh"

module csr_file import csr_rs_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  csr_issue_t issue,
  output csr_done_t  done
);

  localparam int NCSR = 1 << `CSR_IDX_W;

  logic [`CSR_DATA_W-1:0] csr_q [NCSR];
  logic [`CSR_IDX_W-1:0]  idx;
  logic [`CSR_DATA_W-1:0] old_val;
  logic [`CSR_DATA_W-1:0] new_val;
  logic                   done_valid_q;
  logic [31:0]            done_inst_q;
  logic [`CSR_TAG_W-1:0]  done_rd_q;
  logic [`CSR_DATA_W-1:0] done_old_q;

  always_comb begin
    idx     = issue.csr_addr[`CSR_IDX_W-1:0];  // upper address bits alias
    old_val = csr_q[idx];
    case (issue.op)
      CSR_RW:  new_val = issue.operand;
      CSR_RS:  new_val = old_val | issue.operand;
      CSR_RC:  new_val = old_val & ~issue.operand;
      default: new_val = old_val;  // unused encoding leaves the CSR alone
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NCSR; i++) begin
        csr_q[i] <= '0;
      end
      done_valid_q <= 1'b0;
    end else begin
      done_valid_q <= issue.valid;
      if (issue.valid) csr_q[idx] <= new_val;  // same edge that registers done
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      done_inst_q <= issue.inst_num;
      done_rd_q   <= issue.rd;
      done_old_q  <= old_val;  // the instruction's rd result
    end
  end

  assign done = '{valid: done_valid_q, inst_num: done_inst_q, rd: done_rd_q,
                  old_val: done_old_q};

endmodule

// ==== hdl/csr_issue_top.sv ====
`timescale 1ns/10ps
`include "csr_rs_cfg.svh"

module csr_issue_top import csr_rs_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          flush,
  input  csr_dispatch_t dispatch,
  input  logic          dispatch_valid,
  input  wakeup_t       ext_wake [`CSR_WAKE_PORTS],
  output logic          full,
  output csr_done_t     done
);

  wakeup_t    wake [`CSR_WAKE_PORTS+1];  // external ports, then the CSR done
  csr_issue_t issue;

  wakeup_merge i_wakeup_merge (
    .clk      (clk),
    .rst_n    (rst_n),
    .ext_wake (ext_wake),
    .csr_done (done),
    .wake     (wake)
  );

  csr_station i_csr_station (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch       (dispatch),
    .dispatch_valid (dispatch_valid),
    .wake           (wake),
    .full           (full),
    .issue          (issue)
  );

  // an issue registered before a flush still completes here
  csr_file i_csr_file (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue),
    .done  (done)
  );

endmodule

// ==== test/csr_checker.sv ====
`timescale 1ns/10ps
`include "csr_rs_cfg.svh"

module csr_checker import csr_rs_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          flush,
  input  csr_dispatch_t dispatch,
  input  logic          dispatch_valid,
  input  wakeup_t       ext_wake [`CSR_WAKE_PORTS],
  input  logic          full,
  input  csr_done_t     done,
  input  logic          end_test,
  input  int            test_num,
  input  logic          check_full,
  input  logic          expect_full,
  output int            errors,
  output int            outstanding,
  output int            tests_failed
);

  logic [31:0] model [8];
  logic        pend [256];
  logic        res [256];
  logic [31:0] operand [256];
  logic [7:0]  src [256];
  logic [7:0]  rd [256];
  logic [2:0]  idx [256];
  csr_op_e     op [256];
  int          errors_at_start;

  // lowest external port wins, the CSR done comes last like in the station
  function automatic logic lookup_wake(input logic [7:0] tag, output logic [31:0] data);
    data = '0;
    for (int p = 0; p < `CSR_WAKE_PORTS; p++) begin
      if (ext_wake[p].valid && ext_wake[p].tag != 0 && ext_wake[p].tag == tag) begin
        data = ext_wake[p].data;
        return 1'b1;
      end
    end
    if (done.valid && done.rd == tag) begin
      data = done.old_val;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  always @(posedge clk) begin
    logic [7:0]  n;
    logic [31:0] wdata;
    logic [31:0] old;
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) model[i] = '0;
      for (int i = 0; i < 256; i++) pend[i] = 1'b0;
      errors = 0;
      outstanding = 0;
      tests_failed = 0;
      errors_at_start = 0;
    end else begin
      if (done.valid) begin
        n = done.inst_num[7:0];
        if (done.inst_num > 255 || !pend[n]) begin
          $display("done for unknown or flushed instruction %0d", done.inst_num);
          errors++;
        end else if (!res[n]) begin
          $display("instruction %0d completed before its operand was woken", n);
          errors++;
        end else begin
          old = model[idx[n]];
          if (done.rd != rd[n]) begin
            $display("FAILED done.rd got %h expected %h", done.rd, rd[n]);
            errors++;
          end
          if (done.old_val != old) begin
            $display("FAILED done.old_val got %h expected %h", done.old_val, old);
            errors++;
          end
          case (op[n])
            CSR_RW:  model[idx[n]] = operand[n];
            CSR_RS:  model[idx[n]] = old | operand[n];
            default: model[idx[n]] = old & ~operand[n];
          endcase
          pend[n] = 1'b0;
          outstanding--;
        end
      end
      for (int i = 0; i < 256; i++) begin
        if (pend[i] && !res[i] && lookup_wake(src[i], wdata)) begin
          res[i] = 1'b1;
          operand[i] = wdata;
        end
      end
      if (flush) begin
        for (int i = 0; i < 256; i++) pend[i] = 1'b0;
        outstanding = 0;
      end else if (dispatch_valid && !full) begin
        n = dispatch.inst_num[7:0];
        pend[n] = 1'b1;
        src[n] = dispatch.src;
        rd[n] = dispatch.rd;
        idx[n] = dispatch.csr_addr[2:0];
        op[n] = dispatch.op;
        res[n] = 1'b1;
        if (dispatch.use_imm) operand[n] = {27'd0, dispatch.imm};
        else if (dispatch.src_ready) operand[n] = dispatch.src_data;
        else res[n] = lookup_wake(dispatch.src, operand[n]);
        outstanding++;
      end
      if (check_full && full != expect_full) begin
        $display("FAILED full got %h expected %h", full, expect_full);
        errors++;
      end
      if (end_test) begin
        if (outstanding != 0) begin
          $display("%0d instructions still outstanding at end of test", outstanding);
          errors++;
        end
        if (errors == errors_at_start) begin
          $display("test %0d passed", test_num);
        end else begin
          $display("test %0d failed with %0d errors", test_num, errors - errors_at_start);
          tests_failed++;
        end
        errors_at_start = errors;
      end
    end
  end

endmodule

// ==== test/tb_csr_top.sv ====
`timescale 1ns/10ps
`include "csr_rs_cfg.svh"

module tb_csr_top;
  import csr_rs_pkg::*;

  localparam int BUDGET = 16 + 24 * 4 + 8 * 8 + 4 * 6 + 40 + 40 + 12 * 8 + 6 * 20;
  localparam int LIMIT  = 2 * BUDGET;

  logic          clk;
  logic          rst_n;
  logic          flush;
  logic          dispatch_valid;
  logic          full;
  logic          end_test;
  logic          check_full;
  logic          expect_full;
  int            test_num;
  csr_dispatch_t dispatch;
  wakeup_t       ext_wake [`CSR_WAKE_PORTS];
  csr_done_t     done;
  int            errors;
  int            outstanding;
  int            tests_failed;
  int            cycles;
  logic [31:0]   lfsr;
  logic [31:0]   inst_cnt;
  logic [31:0]   v;

  csr_issue_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch       (dispatch),
    .dispatch_valid (dispatch_valid),
    .ext_wake       (ext_wake),
    .full           (full),
    .done           (done)
  );

  csr_checker i_chk (
    .clk (clk), .rst_n (rst_n), .flush (flush), .dispatch (dispatch),
    .dispatch_valid (dispatch_valid), .ext_wake (ext_wake), .full (full), .done (done),
    .end_test (end_test), .test_num (test_num), .check_full (check_full),
    .expect_full (expect_full), .errors (errors), .outstanding (outstanding),
    .tests_failed (tests_failed)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("run timed out after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  task automatic rnd(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    dispatch_valid = 1'b0;
    flush = 1'b0;
    end_test = 1'b0;
    check_full = 1'b0;
    for (int p = 0; p < `CSR_WAKE_PORTS; p++) ext_wake[p].valid = 1'b0;
  endtask

  task automatic send_csr(input logic use_imm, input logic [7:0] src, input logic src_ready,
                          input logic [31:0] data);
    logic [31:0] r;
    next_cycle();
    dispatch = '0;
    dispatch.inst_num = inst_cnt;
    dispatch.rd = 8'h80 | inst_cnt[6:0];  // rd tags never collide with external tags
    dispatch.src = src;
    dispatch.src_ready = src_ready;
    dispatch.src_data = data;
    dispatch.use_imm = use_imm;
    rnd(5, r);
    dispatch.imm = r[4:0];
    rnd(12, r);
    dispatch.csr_addr = r[11:0];
    rnd(2, r);
    dispatch.op = (r[1:0] == 2'b00) ? CSR_RW : csr_op_e'(r[1:0]);
    dispatch_valid = 1'b1;
    inst_cnt++;
  endtask

  task automatic set_wake(input int port, input logic [7:0] tag, input logic [31:0] data);
    ext_wake[port].valid = 1'b1;
    ext_wake[port].tag = tag;
    ext_wake[port].data = data;
  endtask

  task automatic finish_test();
    next_cycle();
    while (outstanding != 0) next_cycle();
    end_test = 1'b1;
    next_cycle();
    test_num++;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    end_test = 1'b0;
    check_full = 1'b0;
    expect_full = 1'b0;
    dispatch = '0;
    for (int p = 0; p < `CSR_WAKE_PORTS; p++) ext_wake[p] = '0;
    test_num = 1;
    cycles = 0;
    inst_cnt = 0;
    lfsr = 32'd91815;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 24; i++) send_csr(1'b1, 8'h00, 1'b1, '0);  // immediate forms
    finish_test();

    for (int i = 0; i < 8; i++) send_csr(1'b0, 8'h10 + 8'(i), 1'b0, '0);
    repeat (4) next_cycle();
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      rnd(32, v);
      set_wake(int'(i % `CSR_WAKE_PORTS), 8'h10 + 8'(i), v);
    end
    finish_test();

    for (int i = 0; i < 4; i++) begin
      rnd(32, v);
      send_csr(1'b0, 8'h30, 1'b0, '0);
      set_wake(0, 8'h30, v);  // producer in the dispatch cycle
      next_cycle();
      set_wake(1, 8'h30, ~v);
    end
    finish_test();

    for (int i = 0; i < 16; i++) send_csr(1'b0, 8'h40, 1'b0, '0);
    next_cycle();
    check_full = 1'b1;
    expect_full = 1'b1;
    next_cycle();
    rnd(32, v);
    set_wake(2, 8'h40, v);
    repeat (20) next_cycle();
    check_full = 1'b1;
    expect_full = 1'b0;
    finish_test();

    for (int i = 0; i < 6; i++) send_csr(1'b0, 8'h50, 1'b0, '0);
    repeat (3) next_cycle();
    flush = 1'b1;
    repeat (3) next_cycle();
    set_wake(3, 8'h50, 32'hdead_beef);
    repeat (20) next_cycle();
    finish_test();

    for (int i = 0; i < 6; i++) begin
      send_csr(1'b1, 8'h00, 1'b1, '0);
      send_csr(1'b0, 8'h80 | 8'(inst_cnt[6:0] - 7'd1), 1'b0, '0);  // waits on the CSR done
    end
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", test_num - 1, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/csr_rs_pkg.sv
hdl/wakeup_merge.sv
hdl/csr_station.sv
hdl/csr_file.sv
hdl/csr_issue_top.sv
test/csr_checker.sv
test/tb_csr_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csr_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
